// ==== Bender.yml ====
package:
  name: vic_timing

sources:
  - files:
      - hw/vic_pkg.sv
      - hw/phase_gen.sv
      - hw/raster_counter.sv
      - hw/beam_sync.sv
      - hw/raster_irq.sv
      - hw/vic_timing.sv
  - target: test
    files:
      - tests/clk_gen.sv
      - tests/vic_timing_props.sv
      - tests/tb_vic_timing.sv

// ==== hw/beam_sync.sv ====
`timescale 1ns/1ps

module beam_sync (
   input  logic               clk_dot4x,
   input  logic               rst,
   input  vic_pkg::chip_t     chip,
   input  vic_pkg::beam_pos_t beam,
   output logic               hsync,
   output logic               vsync,
   output logic               csync
);

   // sync windows of the selected chip
   vic_pkg::chip_limits_t lim;

   // unregistered window decodes
   logic h_win;
   logic v_win;

   always_comb begin
      lim = vic_pkg::chip_limits(chip);
   end

   // half open windows, start inclusive and end exclusive
   always_comb begin
      h_win = (beam.raster_x >= lim.hsync_start) && (beam.raster_x < lim.hsync_end);
      v_win = (beam.raster_line >= lim.vblank_start) && (beam.raster_line < lim.vblank_end);
   end

   // registered so the pins never see compare glitches
   // all three levels leave one tick after the beam position
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         hsync <= 1'b0;
         vsync <= 1'b0;
         // composite sync idles high
         csync <= 1'b1;
      end else begin
         hsync <= h_win;
         vsync <= v_win;
         // active low, pulled down by either window
         csync <= ~(h_win | v_win);
      end
   end

endmodule

// ==== hw/phase_gen.sv ====
`timescale 1ns/1ps

module phase_gen (
   input  logic clk_dot4x,
   input  logic rst,
   output logic clk_dot,
   output logic clk_phi,
   output logic dot_strobe
);

   // all three rings rotate toward the msb every tick
   // bit 0 is the tap, so the tap sees the ring contents from bit 0
   // downward through bit n-1, bit n-2 and so on
   logic [vic_pkg::dot_ticks-1:0] dot_ring;
   logic [vic_pkg::dot_ticks-1:0] rise_ring;
   logic [vic_pkg::phi_ticks-1:0] phi_ring;

   // dot clock ring
   // low on the first tick out of reset, high on the next two,
   // so the first tick already sits in the second half of pixel 0
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         dot_ring <= {{(vic_pkg::dot_ticks/2){1'b1}}, {(vic_pkg::dot_ticks/2){1'b0}}};
      end else begin
         dot_ring <= {dot_ring[vic_pkg::dot_ticks-2:0], dot_ring[vic_pkg::dot_ticks-1]};
      end
   end

   // dot rising ring
   // one hot, tap is high on the tick before clk_dot goes high
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         rise_ring <= {{(vic_pkg::dot_ticks-1){1'b0}}, 1'b1};
      end else begin
         rise_ring <= {rise_ring[vic_pkg::dot_ticks-2:0], rise_ring[vic_pkg::dot_ticks-1]};
      end
   end

   // phi ring
   // the low bits hold the one tick of pixel 0 plus pixels 1..3,
   // then half a cycle of high for pixels 4..7
   // phi flips on the same edges as raster_x bit 2
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_ring <= {{(vic_pkg::phi_ticks/2 - vic_pkg::dot_ticks){1'b0}},
                      {(vic_pkg::dot_ticks*vic_pkg::dots_per_cycle/2){1'b1}},
                      {vic_pkg::dot_ticks{1'b0}}};
      end else begin
         phi_ring <= {phi_ring[vic_pkg::phi_ticks-2:0], phi_ring[vic_pkg::phi_ticks-1]};
      end
   end

   // fixed taps, straight from flops
   assign clk_dot    = dot_ring[0];
   assign clk_phi    = phi_ring[0];
   // raster counter steps on this tick, lining up with the clk_dot rise
   assign dot_strobe = rise_ring[0];

endmodule

// ==== hw/raster_counter.sv ====
`timescale 1ns/1ps

module raster_counter (
   input  logic               clk_dot4x,
   input  logic               rst,
   input  vic_pkg::chip_t     chip,
   input  logic               dot_strobe,
   output vic_pkg::beam_pos_t beam
);

   // limits for the selected chip
   vic_pkg::chip_limits_t lim;
   // last line in 9 bit form for the line compare
   vic_pkg::raster_y_t    y_last;

   // beam counters
   vic_pkg::raster_x_t    x_cnt;
   vic_pkg::raster_y_t    y_cnt;

   // wrap conditions
   logic                  x_wrap;
   logic                  y_wrap;

   // chip is static between resets, so this is a plain decode
   always_comb begin
      lim    = vic_pkg::chip_limits(chip);
      y_last = lim.y_max[8:0];
   end

   always_comb begin
      x_wrap = (x_cnt == lim.x_max);
      y_wrap = (y_cnt == y_last);
   end

   // counters only move on the dot tick
   // x and clk_dot change on the same clk_dot4x edge
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         x_cnt <= '0;
         y_cnt <= '0;
      end else if (dot_strobe) begin
         if (x_wrap) begin
            // end of line, back to pixel 0
            x_cnt <= '0;
            // line steps or the frame wraps
            if (y_wrap) begin
               y_cnt <= '0;
            end else begin
               y_cnt <= y_cnt + 9'd1;
            end
         end else begin
            x_cnt <= x_cnt + 10'd1;
         end
      end
   end

   // line_start spans the whole of pixel 0
   // four ticks after a wrap, one tick right after reset
   always_comb begin
      beam.raster_x    = x_cnt;
      beam.raster_line = y_cnt;
      beam.line_start  = (x_cnt == '0);
   end

endmodule

// ==== hw/raster_irq.sv ====
`timescale 1ns/1ps

module raster_irq (
   input  logic               clk_dot4x,
   input  logic               rst,
   input  vic_pkg::beam_pos_t beam,
   input  vic_pkg::raster_y_t irq_compare,
   input  logic               irq_enable,
   input  logic               irq_clear,
   output logic               irq
);

   // line_start one tick back, for edge detection
   logic line_start_d;
   // first tick of a new line
   logic line_first;
   // compare already fired on the current line
   logic fired;
   // raster event latch, held until cleared
   logic irq_latch;
   // set request for the latch this tick
   logic irq_set;

   always_comb begin
      line_first = beam.line_start & ~line_start_d;
      irq_set    = line_first & ~fired & (beam.raster_line == irq_compare);
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         line_start_d <= 1'b0;
         fired        <= 1'b0;
         irq_latch    <= 1'b0;
      end else begin
         line_start_d <= beam.line_start;
         // the once per line flag is updated only at line start
         if (line_first) begin
            fired <= (beam.raster_line == irq_compare);
         end
         // set has priority over a clear in the same tick
         if (irq_set) begin
            irq_latch <= 1'b1;
         end else if (irq_clear) begin
            irq_latch <= 1'b0;
         end
      end
   end

   // condition is latched even while masked
   // enabling later shows a pending event straight away
   assign irq = irq_latch & irq_enable;

endmodule

// ==== hw/vic_pkg.sv ====
package vic_pkg;

   // clk_dot4x ticks per pixel
   localparam int dot_ticks = 4;
   // clk_dot4x ticks per full phi period
   localparam int phi_ticks = 32;
   // pixels per phi cycle, half in each phase
   localparam int dots_per_cycle = 8;

   // supported chip variants
   // 6567R8 and 6567R56A are ntsc parts, 6569 is pal
   typedef enum logic [1:0] {
      chip_6567r8   = 2'd0,
      chip_6567r56a = 2'd1,
      chip_6569     = 2'd2
   } chip_t;

   // horizontal pixel position within a line
   typedef logic [9:0] raster_x_t;
   // raster line number within a frame
   typedef logic [8:0] raster_y_t;

   // per chip raster limits and sync windows
   // x_max and y_max are the last valid positions, not the counts
   typedef struct packed {
      raster_x_t x_max;
      raster_x_t y_max;
      raster_x_t hsync_start;
      raster_x_t hsync_end;
      raster_y_t vblank_start;
      raster_y_t vblank_end;
   } chip_limits_t;

   // beam position as seen by the sync and irq logic
   typedef struct packed {
      raster_x_t raster_x;
      raster_y_t raster_line;
      // high while raster_x is 0
      logic      line_start;
   } beam_pos_t;

   // limits lookup, pure combinational
   function automatic chip_limits_t chip_limits(input chip_t chip);
      chip_limits_t lim;
      case (chip)
         chip_6567r8: begin
            // 520 pixels by 263 lines
            lim = '{x_max: 10'd519, y_max: 10'd262,
                    hsync_start: 10'd409, hsync_end: 10'd446,
                    vblank_start: 9'd14, vblank_end: 9'd22};
         end
         chip_6567r56a: begin
            // 512 pixels by 262 lines
            lim = '{x_max: 10'd511, y_max: 10'd261,
                    hsync_start: 10'd409, hsync_end: 10'd446,
                    vblank_start: 9'd14, vblank_end: 9'd22};
         end
         default: begin
            // 6569, 504 pixels by 312 lines
            // the unused encoding falls back to pal timing
            lim = '{x_max: 10'd503, y_max: 10'd311,
                    hsync_start: 10'd408, hsync_end: 10'd444,
                    vblank_start: 9'd301, vblank_end: 9'd309};
         end
      endcase
      return lim;
   endfunction

endpackage

// ==== hw/vic_timing.sv ====
`timescale 1ns/1ps

module vic_timing (
   input  logic               clk_dot4x,
   input  logic               rst,
   input  vic_pkg::chip_t     chip,
   input  vic_pkg::raster_y_t irq_compare,
   input  logic               irq_enable,
   input  logic               irq_clear,
   output logic               clk_dot,
   output logic               clk_phi,
   output vic_pkg::raster_x_t raster_x,
   output vic_pkg::raster_y_t raster_line,
   output logic               hsync,
   output logic               vsync,
   output logic               csync,
   output logic               irq
);

   // one tick per pixel, from the phase rings
   logic               dot_strobe;
   // current beam position
   vic_pkg::beam_pos_t beam;

   // dot and phi clocks plus the pixel tick
   phase_gen u_phase_gen (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .clk_dot    (clk_dot),
      .clk_phi    (clk_phi),
      .dot_strobe (dot_strobe)
   );

   // beam x and line counters
   raster_counter u_raster_counter (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .chip       (chip),
      .dot_strobe (dot_strobe),
      .beam       (beam)
   );

   // h, v and composite sync
   beam_sync u_beam_sync (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip      (chip),
      .beam      (beam),
      .hsync     (hsync),
      .vsync     (vsync),
      .csync     (csync)
   );

   // raster compare interrupt
   raster_irq u_raster_irq (
      .clk_dot4x   (clk_dot4x),
      .rst         (rst),
      .beam        (beam),
      .irq_compare (irq_compare),
      .irq_enable  (irq_enable),
      .irq_clear   (irq_clear),
      .irq         (irq)
   );

   // beam position out to the pins
   assign raster_x    = beam.raster_x;
   assign raster_line = beam.raster_line;

endmodule

// ==== tb.f ====
hw/vic_pkg.sv
hw/phase_gen.sv
hw/raster_counter.sv
hw/beam_sync.sv
hw/raster_irq.sv
hw/vic_timing.sv
tests/clk_gen.sv
tests/vic_timing_props.sv
tests/tb_vic_timing.sv

// ==== tests/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
   output logic clk,
   output logic rst
);

   // 10 ns clk_dot4x
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // power on reset, released just after the fifth rising edge
   initial begin
      rst = 1'b1;
      repeat (5) @(posedge clk);
      #1 rst = 1'b0;
   end

endmodule

// ==== tests/tb_vic_timing.sv ====
`timescale 1ns/1ps

module tb_vic_timing;

   // one stimulus row per chip type, expected values written out by hand
   typedef struct packed {
      vic_pkg::chip_t     chip;
      logic [10:0]        line_len;
      logic [9:0]         line_cnt;
      vic_pkg::raster_x_t hs_start;
      vic_pkg::raster_x_t hs_end;
      vic_pkg::raster_y_t vb_start;
      vic_pkg::raster_y_t vb_end;
      vic_pkg::raster_y_t irq_line;
      // 1 runs the enabled irq case, 0 the masked one
      logic               irq_en;
   } row_t;

   localparam int num_rows = 3;

   logic               clk_dot4x;
   logic               rst_por;
   logic               rst_row;
   logic               rst;
   vic_pkg::chip_t     chip;
   vic_pkg::raster_y_t irq_compare;
   logic               irq_enable;
   logic               irq_clear;
   logic               clk_dot;
   logic               clk_phi;
   vic_pkg::raster_x_t raster_x;
   vic_pkg::raster_y_t raster_line;
   logic               hsync;
   logic               vsync;
   logic               csync;
   logic               irq;

   row_t rows [num_rows];
   // row under test, read by the observer
   row_t cur;
   logic checking;
   logic frame_done;
   int   value_errs;
   int   other_errs;
   int   cycles;
   int   limit;

   // reference model state, updated on the falling edge
   vic_pkg::raster_x_t m_x;
   vic_pkg::raster_y_t m_y;
   vic_pkg::raster_x_t px;
   vic_pkg::raster_y_t py;
   logic               m_latch;
   logic               prev_ls;
   logic               prev_dot;
   logic               prev_phi;
   int                 dot_age;
   int                 phi_age;
   logic               dot_seen;
   logic               phi_seen;

   assign rst = rst_por | rst_row;

   clk_gen u_clk_gen (
      .clk (clk_dot4x),
      .rst (rst_por)
   );

   vic_timing UUT (
      .clk_dot4x   (clk_dot4x),
      .rst         (rst),
      .chip        (chip),
      .irq_compare (irq_compare),
      .irq_enable  (irq_enable),
      .irq_clear   (irq_clear),
      .clk_dot     (clk_dot),
      .clk_phi     (clk_phi),
      .raster_x    (raster_x),
      .raster_line (raster_line),
      .hsync       (hsync),
      .vsync       (vsync),
      .csync       (csync),
      .irq         (irq)
   );

   bind vic_timing vic_timing_props u_props (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .clk_dot    (clk_dot),
      .raster_x   (raster_x),
      .hsync      (hsync),
      .vsync      (vsync),
      .csync      (csync),
      .irq        (irq),
      .irq_enable (irq_enable)
   );

   // inputs change 1 ns after the rising edge
   task automatic tick();
      @(posedge clk_dot4x);
      #1;
   endtask

   // one cycle clear strobe, latch drops on the following edge
   task automatic pulse_clear();
      irq_clear = 1'b1;
      tick();
      irq_clear = 1'b0;
      assert (irq == 1'b0) else begin
         value_errs++;
         $display("FAIL irq: got %h, expected %h after clear", irq, 1'b0);
      end
   endtask

   // reset, then one full frame with the irq case of the row
   task automatic run_row(input int i);
      row_t r;
      r = rows[i];
      checking    = 1'b0;
      rst_row     = 1'b1;
      chip        = r.chip;
      irq_compare = r.irq_line;
      irq_enable  = r.irq_en;
      irq_clear   = 1'b0;
      cur         = r;
      repeat (5) tick();
      rst_row  = 1'b0;
      checking = 1'b1;
      if (r.irq_en) begin
         // wait for the compare line to fire
         while (!irq) tick();
         repeat (3) tick();
         assert (irq) else begin
            other_errs++;
            $display("irq did not stay high before the clear");
         end
         pulse_clear();
      end else begin
         // somewhere inside the compare line, after its start
         while (!(raster_line == r.irq_line && raster_x == 10'd8)) tick();
         assert (irq == 1'b0) else begin
            value_errs++;
            $display("FAIL irq: got %h, expected %h while masked", irq, 1'b0);
         end
         irq_enable = 1'b1;
         #1;
         // pending event shows without waiting for an edge
         assert (irq == 1'b1) else begin
            value_errs++;
            $display("FAIL irq: got %h, expected %h on enable", irq, 1'b1);
         end
         tick();
         pulse_clear();
      end
      while (!frame_done) tick();
      checking = 1'b0;
   endtask

   // reference model and cycle checks
   always @(negedge clk_dot4x) begin : observe
      logic dot_rise;
      logic dot_fall;
      logic phi_rise;
      logic exp_h;
      logic exp_v;
      logic set_now;
      if (rst || !checking) begin
         m_x        = '0;
         m_y        = '0;
         px         = '0;
         py         = '0;
         m_latch    = 1'b0;
         prev_ls    = 1'b0;
         prev_dot   = 1'b0;
         prev_phi   = 1'b0;
         dot_age    = 0;
         phi_age    = 0;
         dot_seen   = 1'b0;
         phi_seen   = 1'b0;
         frame_done = 1'b0;
      end else begin
         dot_rise = clk_dot && !prev_dot;
         dot_fall = !clk_dot && prev_dot;
         phi_rise = clk_phi && !prev_phi;
         dot_age++;
         phi_age++;
         // dot clock, 4 cycles per period and high for 2
         if (dot_rise) begin
            if (dot_seen) begin
               assert (dot_age == 4) else begin
                  other_errs++;
                  $display("clk_dot period was %0d cycles instead of 4", dot_age);
               end
            end
            dot_age  = 0;
            dot_seen = 1'b1;
         end
         if (dot_fall && dot_seen) begin
            assert (dot_age == 2) else begin
               other_errs++;
               $display("clk_dot stayed high for %0d cycles instead of 2", dot_age);
            end
         end
         // phi clock, 32 cycles per period
         if (phi_rise) begin
            if (phi_seen) begin
               assert (phi_age == 32) else begin
                  other_errs++;
                  $display("clk_phi period was %0d cycles instead of 32", phi_age);
               end
            end
            phi_age  = 0;
            phi_seen = 1'b1;
         end
         // beam steps on each dot rise
         if (dot_rise) begin
            if (m_x == cur.line_len - 1) begin
               m_x = '0;
               if (m_y == cur.line_cnt - 1) begin
                  m_y        = '0;
                  frame_done = 1'b1;
               end else begin
                  m_y = m_y + 9'd1;
               end
            end else begin
               m_x = m_x + 10'd1;
            end
         end
         assert (raster_x == m_x) else begin
            value_errs++;
            $display("FAIL raster_x: got %h, expected %h", raster_x, m_x);
         end
         assert (raster_line == m_y) else begin
            value_errs++;
            $display("FAIL raster_line: got %h, expected %h", raster_line, m_y);
         end
         assert (clk_phi == m_x[2]) else begin
            value_errs++;
            $display("FAIL clk_phi: got %h, expected %h", clk_phi, m_x[2]);
         end
         // sync levels follow the previous beam position
         exp_h = (px >= cur.hs_start) && (px < cur.hs_end);
         exp_v = (py >= cur.vb_start) && (py < cur.vb_end);
         assert (hsync == exp_h) else begin
            value_errs++;
            $display("FAIL hsync: got %h, expected %h", hsync, exp_h);
         end
         assert (vsync == exp_v) else begin
            value_errs++;
            $display("FAIL vsync: got %h, expected %h", vsync, exp_v);
         end
         assert (csync == !(exp_h || exp_v)) else begin
            value_errs++;
            $display("FAIL csync: got %h, expected %h", csync, !(exp_h || exp_v));
         end
         assert (irq == (m_latch & irq_enable)) else begin
            value_errs++;
            $display("FAIL irq: got %h, expected %h", irq, m_latch & irq_enable);
         end
         // latch update seen from the next cycle, set beats clear
         set_now = (m_x == '0) && !prev_ls && (m_y == cur.irq_line);
         if (set_now) begin
            m_latch = 1'b1;
         end else if (irq_clear) begin
            m_latch = 1'b0;
         end
         prev_ls  = (m_x == '0);
         px       = m_x;
         py       = m_y;
         prev_dot = clk_dot;
         prev_phi = clk_phi;
      end
   end

   // run limit
   always @(posedge clk_dot4x) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("timeout after %0d cycles, the frame never completed", cycles);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'h5b10));
      chip        = vic_pkg::chip_6567r8;
      irq_compare = '0;
      irq_enable  = 1'b0;
      irq_clear   = 1'b0;
      rst_row     = 1'b1;
      checking    = 1'b0;
      frame_done  = 1'b0;
      value_errs  = 0;
      other_errs  = 0;
      cycles      = 0;
      limit       = 0;
      rows[0] = '{chip: vic_pkg::chip_6567r8, line_len: 11'd520, line_cnt: 10'd263,
                  hs_start: 10'd409, hs_end: 10'd446, vb_start: 9'd14, vb_end: 9'd22,
                  irq_line: 9'd0, irq_en: 1'b1};
      rows[1] = '{chip: vic_pkg::chip_6567r56a, line_len: 11'd512, line_cnt: 10'd262,
                  hs_start: 10'd409, hs_end: 10'd446, vb_start: 9'd14, vb_end: 9'd22,
                  irq_line: 9'd0, irq_en: 1'b0};
      rows[2] = '{chip: vic_pkg::chip_6569, line_len: 11'd504, line_cnt: 10'd312,
                  hs_start: 10'd408, hs_end: 10'd444, vb_start: 9'd301, vb_end: 9'd309,
                  irq_line: 9'd0, irq_en: 1'b1};
      // compare line anywhere past line 0 of the frame
      for (int i = 0; i < num_rows; i++) begin
         rows[i].irq_line = 9'(1 + ($urandom % (rows[i].line_cnt - 1)));
      end
      // one frame per row plus margin
      for (int i = 0; i < num_rows; i++) begin
         limit += int'(rows[i].line_len) * int'(rows[i].line_cnt) * 4;
      end
      limit += 1000;
      for (int i = 0; i < num_rows; i++) begin
         run_row(i);
      end
      $display("errors: %0d value, %0d other", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== tests/vic_timing_props.sv ====
`timescale 1ns/1ps

module vic_timing_props (
   input logic               clk_dot4x,
   input logic               rst,
   input logic               clk_dot,
   input vic_pkg::raster_x_t raster_x,
   input logic               hsync,
   input logic               vsync,
   input logic               csync,
   input logic               irq,
   input logic               irq_enable
);

   // the beam only moves on a dot clock rise, and every rise moves it
   dot_moves_x: assert property (@(posedge clk_dot4x) disable iff (rst)
      $rose(clk_dot) |-> (raster_x != $past(raster_x)))
      else $error("clk_dot rose without a raster_x step");

   x_moves_on_dot: assert property (@(posedge clk_dot4x) disable iff (rst)
      (raster_x != $past(raster_x)) |-> $rose(clk_dot))
      else $error("raster_x stepped without a clk_dot rise");

   // composite sync only moves on the tick after a beam step
   csync_after_step: assert property (@(posedge clk_dot4x) disable iff (rst)
      (csync != $past(csync)) |-> ($past(raster_x) != $past(raster_x, 2)))
      else $error("csync changed without a beam step on the tick before");

   // a masked latch must not reach the pin
   irq_masked: assert property (@(posedge clk_dot4x) disable iff (rst)
      !irq_enable |-> !$rose(irq))
      else $error("irq rose while irq_enable was low");

endmodule
